// ==== fxp_sqrt_pkg.sv ====
`default_nettype none

package fxp_sqrt_pkg;

  //==================================================
  // operand format
  //==================================================

  // unsigned q16.16 in and out
  localparam int bit_width = 32;
  localparam int f_bits    = 16;

  //==================================================
  // iteration control
  //==================================================

  // two radicand bits per root bit, radicand scaled by 2^f_bits
  localparam int iter_count = (bit_width + f_bits) / 2;
  localparam int cnt_width  = $clog2(iter_count + 1);

  //==================================================
  // fsm encodings
  //==================================================

  localparam logic [1:0] state_idle = 2'd0;
  localparam logic [1:0] state_calc = 2'd1;
  localparam logic [1:0] state_done = 2'd2;

endpackage

`default_nettype wire

// ==== fxp_sqrt_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fxp_sqrt_ctrl
  import fxp_sqrt_pkg::*;
(
  input  logic clk,
  input  logic reset,

  // input handshake
  input  logic recv_val,
  output logic recv_rdy,

  // output buffer status
  input  logic buf_full,
  input  logic send_val,
  input  logic send_rdy,

  // datapath control
  output logic load,
  output logic step,
  output logic buf_load
);

  logic [1:0]           state;
  logic [1:0]           state_next;
  logic [cnt_width-1:0] iter_cnt;
  logic                 last_step;
  logic                 buf_free;

  //==================================================
  // handshake and datapath strobes
  //==================================================

  // only accept a radicand while nothing is in the engine
  assign recv_rdy = (state == state_idle);
  assign load     = recv_val && recv_rdy;
  assign step     = (state == state_calc);

  assign last_step = step && (iter_cnt == cnt_width'(iter_count - 1));

  // buffer is usable if empty or draining on this edge
  assign buf_free = !buf_full || (send_val && send_rdy);
  assign buf_load = (state == state_done) && buf_free;

  //==================================================
  // next state
  //==================================================

  always_comb begin
    state_next = state;
    case (state)
      state_idle: begin
        if (load) begin
          state_next = state_calc;
        end
      end
      state_calc: begin
        if (last_step) begin
          state_next = state_done;
        end
      end
      state_done: begin
        // single back-pressure point of the unit
        if (buf_load) begin
          state_next = state_idle;
        end
      end
      default: begin
        state_next = state_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= state_idle;
    end else begin
      state <= state_next;
    end
  end

  //==================================================
  // iteration counter
  //==================================================

  // counts steps taken since the last load
  always_ff @(posedge clk) begin
    if (reset) begin
      iter_cnt <= '0;
    end else if (load) begin
      iter_cnt <= '0;
    end else if (step) begin
      iter_cnt <= iter_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== fxp_sqrt_remainder.sv ====
`timescale 1ns/1ps
`default_nettype none

module fxp_sqrt_remainder
  import fxp_sqrt_pkg::*;
(
  input  logic                 clk,
  input  logic                 load,
  input  logic                 step,
  input  logic [bit_width-1:0] recv_msg,
  input  logic [bit_width-1:0] root_value,
  output logic                 root_bit
);

  // partial remainder is two bits wider than the operand
  logic [bit_width+1:0] rem_q;
  logic [bit_width-1:0] rad_q;

  logic [bit_width+1:0] rem_shift;
  logic [bit_width+1:0] trial_sub;
  logic [bit_width+2:0] trial_diff;

  //==================================================
  // trial subtraction
  //==================================================

  // bring down the next two radicand bits
  assign rem_shift = {rem_q[bit_width-1:0], rad_q[bit_width-1 -: 2]};

  // 4 * root + 1
  assign trial_sub = {root_value, 2'b01};

  // one extra bit to catch the borrow
  assign trial_diff = {1'b0, rem_shift} - {1'b0, trial_sub};

  assign root_bit = ~trial_diff[bit_width+2];

  //==================================================
  // remainder and radicand shift registers
  //==================================================

  // the 66-bit pair {rem_q, rad_q} starts as the zero-extended radicand;
  // once rad_q drains, zeros shift in as the f_bits fraction scaling
  always_ff @(posedge clk) begin
    if (load) begin
      {rem_q, rad_q} <= {{(bit_width + 2){1'b0}}, recv_msg};
    end else if (step) begin
      if (root_bit) begin
        rem_q <= trial_diff[bit_width+1:0];
      end else begin
        rem_q <= rem_shift;
      end
      rad_q <= {rad_q[bit_width-3:0], 2'b00};
    end
  end

endmodule

`default_nettype wire

// ==== fxp_sqrt_root.sv ====
`timescale 1ns/1ps
`default_nettype none

module fxp_sqrt_root
  import fxp_sqrt_pkg::*;
(
  input  logic                 clk,
  input  logic                 load,
  input  logic                 step,
  input  logic                 root_bit,
  output logic [bit_width-1:0] root_value
);

  logic [bit_width-1:0] root_q;

  //==================================================
  // root accumulation
  //==================================================

  // msb of the root is decided first
  always_ff @(posedge clk) begin
    if (load) begin
      root_q <= '0;
    end else if (step) begin
      root_q <= {root_q[bit_width-2:0], root_bit};
    end
  end

  // q16.16 after the last step, also the trial divisor meanwhile
  assign root_value = root_q;

endmodule

`default_nettype wire

// ==== fxp_sqrt_out_buf.sv ====
`timescale 1ns/1ps
`default_nettype none

module fxp_sqrt_out_buf
  import fxp_sqrt_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 buf_load,
  input  logic [bit_width-1:0] root_value,
  input  logic                 send_rdy,
  output logic [bit_width-1:0] send_msg,
  output logic                 send_val,
  output logic                 buf_full
);

  logic [bit_width-1:0] data_q;
  logic                 valid_q;

  //==================================================
  // result holding register
  //==================================================

  always_ff @(posedge clk) begin
    if (buf_load) begin
      data_q <= root_value;
    end
  end

  // a reload in the same cycle as a send keeps the entry full
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (buf_load) begin
      valid_q <= 1'b1;
    end else if (send_rdy) begin
      valid_q <= 1'b0;
    end
  end

  //==================================================
  // output port
  //==================================================

  assign send_msg = data_q;
  assign send_val = valid_q;
  assign buf_full = valid_q;

endmodule

`default_nettype wire

// ==== fxp_sqrt.sv ====
`timescale 1ns/1ps
`default_nettype none

module fxp_sqrt
  import fxp_sqrt_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,

  // radicand in, unsigned q16.16
  input  logic [bit_width-1:0] recv_msg,
  input  logic                 recv_val,
  output logic                 recv_rdy,

  // root out, unsigned q16.16
  output logic [bit_width-1:0] send_msg,
  output logic                 send_val,
  input  logic                 send_rdy
);

  logic                 load;
  logic                 step;
  logic                 root_bit;
  logic [bit_width-1:0] root_value;
  logic                 buf_load;
  logic                 buf_full;

  //==================================================
  // control
  //==================================================

  fxp_sqrt_ctrl ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .buf_full (buf_full),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .load     (load),
    .step     (step),
    .buf_load (buf_load)
  );

  //==================================================
  // datapath
  //==================================================

  fxp_sqrt_remainder remainder_i (
    .clk        (clk),
    .load       (load),
    .step       (step),
    .recv_msg   (recv_msg),
    .root_value (root_value),
    .root_bit   (root_bit)
  );

  fxp_sqrt_root root_i (
    .clk        (clk),
    .load       (load),
    .step       (step),
    .root_bit   (root_bit),
    .root_value (root_value)
  );

  // lets the next radicand start while this result waits
  fxp_sqrt_out_buf out_buf_i (
    .clk        (clk),
    .reset      (reset),
    .buf_load   (buf_load),
    .root_value (root_value),
    .send_rdy   (send_rdy),
    .send_msg   (send_msg),
    .send_val   (send_val),
    .buf_full   (buf_full)
  );

endmodule

`default_nettype wire

// ==== fxp_sqrt_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fxp_sqrt_tb;

  localparam logic [31:0] seed           = 32'h766fad7c;
  localparam int          clk_period     = 20;
  localparam int          num_random     = 200;
  localparam int          num_squares    = 8;
  localparam int          num_bp         = 200;
  localparam int          num_reset      = 20;
  localparam int          total_ops      = num_random + 4 + num_squares + num_bp + num_reset + 2;
  localparam int          timeout_cycles = total_ops * 40 + 500;

  logic        clk;
  logic        reset;
  logic [31:0] recv_msg;
  logic        recv_val;
  logic        recv_rdy;
  logic [31:0] send_msg;
  logic        send_val;
  logic        send_rdy;

  logic [31:0] lfsr;
  logic [31:0] model_q[$];
  logic        bp_on;
  string       test_name;
  int          in_count;
  int          out_count;
  int          checks;
  int          errors;

  fxp_sqrt fxp_sqrt_i (
    .clk      (clk),
    .reset    (reset),
    .recv_msg (recv_msg),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_msg (send_msg),
    .send_val (send_val),
    .send_rdy (send_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  //==================================================
  // random bits and reference model
  //==================================================

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hb4bcd35c;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic logic rand_bit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr_step(lfsr);
    return b;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], rand_bit()};
    end
    return r;
  endfunction

  // random shift spreads operands over all magnitudes
  function automatic logic [31:0] rand_operand();
    logic [31:0] v;
    logic [4:0]  sh;
    v  = rand_bits(32);
    sh = 5'(rand_bits(5));
    return v >> sh;
  endfunction

  // largest r with r*r <= x * 2^16, by binary search
  function automatic logic [31:0] model_sqrt(input logic [31:0] x);
    logic [63:0] v;
    logic [63:0] lo;
    logic [63:0] hi;
    logic [63:0] mid;
    v  = {16'h0000, x, 16'h0000};
    lo = 64'd0;
    hi = 64'd1 << 24;
    while (hi - lo > 64'd1) begin
      mid = (lo + hi) >> 1;
      if (mid * mid <= v) begin
        lo = mid;
      end else begin
        hi = mid;
      end
    end
    return lo[31:0];
  endfunction

  task automatic note_failure(input string what);
    errors++;
    $display("%s: %s", test_name, what);
  endtask

  //==================================================
  // driver
  //==================================================

  task automatic next_cycle();
    @(posedge clk);
    #1;
    if (bp_on) begin
      send_rdy = rand_bit();
    end else begin
      send_rdy = 1'b1;
    end
  endtask

  // holds the operand until the edge where recv_rdy takes it
  task automatic send_op(input logic [31:0] value);
    logic accepted;
    recv_msg = value;
    recv_val = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk);
      accepted = recv_rdy;
      next_cycle();
    end
    recv_val = 1'b0;
  endtask

  task automatic wait_drain();
    while (model_q.size() != 0) begin
      next_cycle();
    end
  endtask

  //==================================================
  // monitor and scoreboard
  //==================================================

  // values at the falling edge are the ones the next rising edge uses
  always @(negedge clk) begin
    logic [31:0] expected;
    if (!reset) begin
      if (recv_rdy && (in_count - out_count) > 1) begin
        note_failure("input ready while the engine and the output buffer are both busy");
      end
      if (recv_val && recv_rdy) begin
        model_q.push_back(model_sqrt(recv_msg));
        in_count++;
      end
      if (send_val && send_rdy) begin
        out_count++;
        if (model_q.size() == 0) begin
          note_failure("result sent with no operand outstanding");
        end else begin
          expected = model_q.pop_front();
          checks++;
          if (send_msg !== expected) begin
            errors++;
            $display("ERROR %s: expected %h, actual %h", test_name, expected, send_msg);
          end
          // engine and buffer hold at most two operands
          if ((in_count - out_count) > 1) begin
            note_failure("more than two operands in flight at an output transfer");
          end
        end
      end
    end
  end

  initial begin
    repeat (timeout_cycles) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("TEST FAILED");
    $finish;
  end

  //==================================================
  // test sequence
  //==================================================

  initial begin
    logic [63:0] root_exact;
    logic [63:0] root_sq;
    int          gap;
    lfsr      = seed;
    reset     = 1'b1;
    recv_msg  = '0;
    recv_val  = 1'b0;
    send_rdy  = 1'b1;
    bp_on     = 1'b0;
    test_name = "reset";
    in_count  = 0;
    out_count = 0;
    checks    = 0;
    errors    = 0;
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;

    test_name = "random_no_bp";
    for (int i = 0; i < num_random; i++) begin
      send_op(rand_operand());
    end
    wait_drain();

    test_name = "corner";
    send_op(32'h00000000);
    send_op(32'h00000001);
    send_op(32'h00010000);
    send_op(32'hffffffff);
    // root with its low 8 bits clear squares to an exact operand
    for (int i = 0; i < num_squares; i++) begin
      root_exact = 64'(rand_bits(16)) << 8;
      root_sq    = root_exact * root_exact;
      if (model_sqrt(root_sq[47:16]) != root_exact[31:0]) begin
        note_failure("reference model does not return the exact root of a square");
      end
      send_op(root_sq[47:16]);
    end
    wait_drain();

    test_name = "random_bp";
    bp_on = 1'b1;
    for (int i = 0; i < num_bp; i++) begin
      send_op(rand_operand());
      gap = int'(rand_bits(3));
      repeat (gap) next_cycle();
    end
    wait_drain();
    repeat (4) next_cycle();
    if (out_count != num_random + 4 + num_squares + num_bp) begin
      note_failure("results were lost or duplicated under back-pressure");
    end

    test_name = "reset_mid_calc";
    send_op(rand_operand());
    send_op(rand_operand());
    repeat (10) next_cycle();
    reset    = 1'b1;
    recv_val = 1'b0;
    next_cycle();
    next_cycle();
    model_q.delete();
    in_count  = 0;
    out_count = 0;
    reset     = 1'b0;
    bp_on     = 1'b0;
    send_rdy  = 1'b1;
    @(negedge clk);
    if (send_val !== 1'b0) begin
      note_failure("send_val is not low after reset");
    end
    if (recv_rdy !== 1'b1) begin
      note_failure("recv_rdy is not high after reset");
    end
    next_cycle();
    for (int i = 0; i < num_reset; i++) begin
      send_op(rand_operand());
    end
    wait_drain();
    repeat (4) next_cycle();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== fxp_sqrt.f ====
fxp_sqrt_pkg.sv
fxp_sqrt_ctrl.sv
fxp_sqrt_remainder.sv
fxp_sqrt_root.sv
fxp_sqrt_out_buf.sv
fxp_sqrt.sv
fxp_sqrt_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fxp_sqrt testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir
exe=fxp_sqrt_sim

verilator --binary --timing --timescale 1ns/1ps \
  --top-module fxp_sqrt_tb \
  -f fxp_sqrt.f \
  --Mdir "$obj" -o "$exe"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$obj/$exe" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if [ ! -s "$log" ]; then
  echo "simulation log is empty"
  exit 1
fi

# the testbench prints the fail message on any error or timeout
if grep -q "TEST FAILED" "$log"; then
  echo "simulation reported a failure, see $log"
  exit 1
fi

echo "simulation passed, see $log"
exit 0
